// File: files.f
cfg_pkg.sv
axil_ctrl_port.sv
cfg_regs.sv
dma_desc_chan.sv
qsfp_gpio_io.sv
pcie_config_top.sv
tb_pcie_config.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_pcie_config -f files.f -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
  exit 0
else
  exit 1
fi

// File: tb_pcie_config.sv
`default_nettype none

module tb_pcie_config;

  import cfg_pkg::*;

  localparam int WAIT_LIMIT    = 50;
  localparam int RESET_READS   = 15;
  localparam int GPIO_ROUNDS   = 20;
  localparam int DESC_ROUNDS   = 30;
  localparam int STATUS_ROUNDS = 10;
  localparam int CMD_ROUNDS    = 15;
  // Reads and writes issued by the main sequence
  localparam int TXN_COUNT = RESET_READS + 3 * GPIO_ROUNDS + 5 * DESC_ROUNDS +
                             2 * STATUS_ROUNDS + 4 * CMD_ROUNDS;
  // Worst case per access, response timeout plus ready delay
  localparam int TXN_CYCLES = WAIT_LIMIT + 8;
  localparam int WATCHDOG_LIMIT = (TXN_COUNT * TXN_CYCLES + 40) * 8;

  logic pcie_clk;
  logic pcie_rst;
  axil_req_t req;
  axil_rsp_t rsp;
  dma_desc_t rd_desc, wr_desc;
  logic rd_valid, wr_valid, rd_ready, wr_ready;
  dma_status_t rd_status, wr_status;
  host_cmd_t cmd;
  logic cmd_valid, cmd_ready;
  gpio_in_t pins_in;
  gpio_out_t pins_out;
  logic scl_t, sda_t, dma_en;

  integer seed = 95;
  integer errors = 0;

  // Reference model state
  dma_desc_t m_desc [2];
  logic m_dvalid [2];
  logic [31:0] m_tags [2];
  logic [31:0] m_gpio, m_out1, m_out2;
  gpio_in_t m_in1, m_in2;
  logic m_en;
  logic [31:0] m_cmd_data;
  logic [3:0] m_cmd_code, m_cmd_dest;
  logic m_cmd_valid;
  logic m_awready;
  logic m_arready;
  logic m_bvalid;
  logic m_rvalid;
  logic wr_take;
  logic rd_take;
  logic [31:0] exp_rdata;

  pcie_config_top dut0 (
    .pcie_clk(pcie_clk), .pcie_rst(pcie_rst),
    .axil_req_i(req), .axil_rsp_o(rsp),
    .dma_rd_desc_o(rd_desc), .dma_rd_desc_valid_o(rd_valid), .dma_rd_desc_ready_i(rd_ready),
    .dma_wr_desc_o(wr_desc), .dma_wr_desc_valid_o(wr_valid), .dma_wr_desc_ready_i(wr_ready),
    .dma_rd_status_i(rd_status), .dma_wr_status_i(wr_status),
    .host_cmd_o(cmd), .host_cmd_valid_o(cmd_valid), .host_cmd_ready_i(cmd_ready),
    .gpio_in_i(pins_in), .gpio_out_o(pins_out),
    .scl_t_o(scl_t), .sda_t_o(sda_t), .pcie_dma_enable_o(dma_en)
  );

  initial begin
    pcie_clk = 1'b0;
    forever #4 pcie_clk = ~pcie_clk;
  end

  task automatic check(input logic [159:0] actual, input logic [159:0] expected,
                       input string msg);
    if (actual !== expected) begin
      errors = errors + 1;
      $display("[FAIL] %0t %s: got %0h expected %0h", $time, msg, actual, expected);
    end
  endtask

  // Register word as driven on the QSFP and I2C pins
  function automatic gpio_out_t word_to_pins(input logic [31:0] w);
    gpio_out_t p;
    p = {w[9], w[0], w[2], w[11], w[4], w[6], w[16], w[17]};
    return p;
  endfunction

  function automatic logic [31:0] gpio_in_word(input logic [31:0] out_w, input gpio_in_t pin);
    logic [31:0] w;
    w = out_w & 32'h0000_0A55;
    w[1] = pin.qsfp0_intl;
    w[5] = pin.qsfp1_intl;
    w[8] = pin.qsfp0_modprsl;
    w[10] = pin.qsfp1_modprsl;
    w[16] = pin.scl_i;
    w[17] = pin.sda_i;
    return w;
  endfunction

  function automatic logic [31:0] predict_read(input logic [15:0] a);
    case (a)
      ADDR_FW_ID: return FW_ID;
      ADDR_FW_VER: return FW_VER;
      ADDR_BOARD_ID: return BOARD_ID;
      ADDR_BOARD_VER: return BOARD_VER;
      ADDR_PHC_OFFSET: return PHC_OFFSET;
      ADDR_PHC_STRIDE: return PHC_STRIDE;
      ADDR_IF_COUNT: return IF_COUNT;
      ADDR_IF_STRIDE: return IF_STRIDE;
      ADDR_IF_CTRL_OFFSET: return IF_CTRL_OFFSET;
      ADDR_FPGA_ID: return FPGA_ID;
      ADDR_GPIO_OUT: return m_gpio;
      ADDR_GPIO_IN: return gpio_in_word(m_out2, m_in2);
      ADDR_DMA_EN: return {31'd0, m_en};
      16'h0458: return m_tags[0];
      16'h0478: return m_tags[1];
      default: return 32'd0;
    endcase
  endfunction

  task automatic apply_write(input logic [15:0] a, input logic [31:0] d, input logic [3:0] s);
    int ch;
    if (s[0]) m_gpio = (a == ADDR_GPIO_OUT) ? ((m_gpio & ~32'h55) | (d & 32'h55)) : m_gpio;
    if (s[1]) m_gpio = (a == ADDR_GPIO_OUT) ? ((m_gpio & ~32'hA00) | (d & 32'hA00)) : m_gpio;
    if (s[2]) m_gpio = (a == ADDR_GPIO_OUT) ? ((m_gpio & ~32'h30000) | (d & 32'h30000)) : m_gpio;
    if (a == ADDR_DMA_EN) m_en = d[0];
    if (a == ADDR_CMD_DATA) m_cmd_data = d;
    if (a == ADDR_CMD) begin
      m_cmd_code = d[3:0];
      m_cmd_dest = d[11:8];
      m_cmd_valid = 1'b1;
    end
    if (a[15:5] == 11'h022 || a[15:5] == 11'h023) begin
      ch = a[5];
      case (a[4:0])
        5'h00: m_desc[ch].pcie_addr[31:0] = d;
        5'h04: m_desc[ch].pcie_addr[63:32] = d;
        5'h08: m_desc[ch].ram_addr = d;
        5'h10: m_desc[ch].len = d[15:0];
        5'h14: begin
          m_desc[ch].tag = d;
          m_dvalid[ch] = 1'b1;
        end
        default: ;
      endcase
    end
  endtask

  // Compare outputs with the model, then advance it by one edge
  always @(posedge pcie_clk) begin
    if (pcie_rst) begin
      m_dvalid[0] = 1'b0;
      m_dvalid[1] = 1'b0;
      m_tags[0] = '0;
      m_tags[1] = '0;
      m_gpio = 32'h0003_0A11;
      m_out1 = m_gpio;
      m_out2 = m_gpio;
      m_in1 = 6'b000011;
      m_in2 = 6'b000011;
      m_en = 1'b1;
      m_cmd_valid = 1'b0;
      m_awready = 1'b0;
      m_arready = 1'b0;
      m_bvalid = 1'b0;
      m_rvalid = 1'b0;
    end else begin
      check(rsp.awready, m_awready, "awready");
      check(rsp.wready, m_awready, "wready");
      check(rsp.arready, m_arready, "arready");
      check(rsp.bvalid, m_bvalid, "bvalid");
      check(rsp.rvalid, m_rvalid, "rvalid");
      check(rd_valid, m_dvalid[0], "rd desc valid");
      check(wr_valid, m_dvalid[1], "wr desc valid");
      check(cmd_valid, m_cmd_valid, "cmd valid");
      if (m_dvalid[0] && rd_ready) check(rd_desc, m_desc[0], "rd descriptor");
      if (m_dvalid[1] && wr_ready) check(wr_desc, m_desc[1], "wr descriptor");
      if (m_cmd_valid && cmd_ready) check(cmd, {m_cmd_code, m_cmd_dest, m_cmd_data}, "command");
      check(pins_out, word_to_pins(m_out2), "gpio pins");
      check(scl_t, m_out2[16], "scl enable");
      check(sda_t, m_out2[17], "sda enable");
      check(dma_en, m_en, "dma enable");
      if (rd_ready) m_dvalid[0] = 1'b0;
      if (wr_ready) m_dvalid[1] = 1'b0;
      if (cmd_ready) m_cmd_valid = 1'b0;
      wr_take = req.awvalid && req.wvalid && !m_bvalid;
      rd_take = req.arvalid && !m_rvalid;
      // Read data is taken from the state before this edge
      if (rd_take) begin
        exp_rdata = predict_read(req.araddr);
        if (req.araddr == 16'h0458) m_tags[0] = rd_status.valid ? rd_status.tag : '0;
        else if (rd_status.valid) m_tags[0] = m_tags[0] | rd_status.tag;
        if (req.araddr == 16'h0478) m_tags[1] = wr_status.valid ? wr_status.tag : '0;
        else if (wr_status.valid) m_tags[1] = m_tags[1] | wr_status.tag;
      end else begin
        if (rd_status.valid) m_tags[0] = m_tags[0] | rd_status.tag;
        if (wr_status.valid) m_tags[1] = m_tags[1] | wr_status.tag;
      end
      m_out2 = m_out1;
      m_out1 = m_gpio;
      m_in2 = m_in1;
      m_in1 = pins_in;
      if (wr_take) apply_write(req.awaddr, req.wdata, req.wstrb);
      m_awready = wr_take;
      m_arready = rd_take;
      if (wr_take) m_bvalid = 1'b1;
      else if (req.bready) m_bvalid = 1'b0;
      if (rd_take) m_rvalid = 1'b1;
      else if (req.rready) m_rvalid = 1'b0;
    end
  end

  task automatic write_reg(input logic [15:0] a, input logic [31:0] d, input logic [3:0] s);
    int n;
    @(posedge pcie_clk);
    #1;
    req.awaddr = a;
    req.wdata = d;
    req.wstrb = s;
    req.awvalid = 1'b1;
    req.wvalid = 1'b1;
    n = 0;
    do begin
      @(posedge pcie_clk);
      n = n + 1;
    end while (!rsp.bvalid && n < WAIT_LIMIT);
    #1;
    req.awvalid = 1'b0;
    req.wvalid = 1'b0;
    if (n >= WAIT_LIMIT) begin
      errors = errors + 1;
      $display("Write to %h never got a response", a);
    end
    repeat ($random(seed) & 3) @(posedge pcie_clk);
    #1 req.bready = 1'b1;
    @(posedge pcie_clk);
    #1 req.bready = 1'b0;
  endtask

  task automatic read_reg(input logic [15:0] a);
    int n;
    @(posedge pcie_clk);
    #1;
    req.araddr = a;
    req.arvalid = 1'b1;
    n = 0;
    do begin
      @(posedge pcie_clk);
      n = n + 1;
    end while (!rsp.rvalid && n < WAIT_LIMIT);
    #1 req.arvalid = 1'b0;
    if (n >= WAIT_LIMIT) begin
      errors = errors + 1;
      $display("Read of %h never returned data", a);
    end else begin
      check(rsp.rdata, exp_rdata, $sformatf("read %h", a));
    end
    repeat ($random(seed) & 3) @(posedge pcie_clk);
    #1 req.rready = 1'b1;
    @(posedge pcie_clk);
    #1 req.rready = 1'b0;
  endtask

  // Background readies, status pulses and pins, offset from the AXI-lite drive
  initial begin : background
    int cnt;
    cnt = 0;
    forever begin
      @(posedge pcie_clk);
      #2;
      rd_ready = ($random(seed) & 1) == 1;
      wr_ready = ($random(seed) & 1) == 1;
      cmd_ready = ($random(seed) & 1) == 1;
      rd_status.valid = ($random(seed) & 3) == 0;
      rd_status.tag = 32'd1 << ($random(seed) & 31);
      wr_status.valid = ($random(seed) & 3) == 0;
      wr_status.tag = 32'd1 << ($random(seed) & 31);
      cnt = cnt + 1;
      if (!pcie_rst && (cnt % 4) == 0) pins_in = 6'($random(seed));
    end
  end

  initial begin : watchdog
    #(WATCHDOG_LIMIT);
    $display("Timeout: the run did not finish within %0d time units", WATCHDOG_LIMIT);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main
    logic [15:0] base;
    req = '0;
    rd_ready = 1'b0;
    wr_ready = 1'b0;
    cmd_ready = 1'b0;
    rd_status = '0;
    wr_status = '0;
    pins_in = 6'b000011;
    pcie_rst = 1'b1;
    repeat (8) @(posedge pcie_clk);
    #1 pcie_rst = 1'b0;

    read_reg(ADDR_FW_ID);
    read_reg(ADDR_FW_VER);
    read_reg(ADDR_BOARD_ID);
    read_reg(ADDR_BOARD_VER);
    read_reg(ADDR_PHC_OFFSET);
    read_reg(ADDR_PHC_STRIDE);
    read_reg(ADDR_IF_COUNT);
    read_reg(ADDR_IF_STRIDE);
    read_reg(ADDR_IF_CTRL_OFFSET);
    read_reg(ADDR_FPGA_ID);
    read_reg(ADDR_DMA_EN);
    read_reg(ADDR_GPIO_OUT);
    read_reg(16'h0010);
    read_reg(16'h0200);
    read_reg(16'h0444);

    // GPIO writes with random strobes, then both readbacks
    repeat (GPIO_ROUNDS) begin
      write_reg(ADDR_GPIO_OUT, $random(seed), 4'($random(seed)));
      read_reg(ADDR_GPIO_OUT);
      read_reg(ADDR_GPIO_IN);
    end

    // Descriptors, readies in the background make rewrites likely
    repeat (DESC_ROUNDS) begin
      base = ($random(seed) & 1) ? ADDR_DMA_WR_BASE : ADDR_DMA_RD_BASE;
      write_reg(base | 16'h00, $random(seed), 4'hF);
      write_reg(base | 16'h04, $random(seed), 4'hF);
      write_reg(base | 16'h08, $random(seed), 4'hF);
      write_reg(base | 16'h10, $random(seed), 4'hF);
      write_reg(base | 16'h14, $random(seed), 4'hF);
    end

    repeat (STATUS_ROUNDS) begin
      read_reg(16'h0458);
      read_reg(16'h0478);
    end

    repeat (CMD_ROUNDS) begin
      write_reg(ADDR_CMD_DATA, $random(seed), 4'hF);
      write_reg(ADDR_CMD, $random(seed), 4'hF);
      write_reg(ADDR_DMA_EN, $random(seed), 4'hF);
      read_reg(ADDR_DMA_EN);
    end

    repeat (20) @(posedge pcie_clk);
    $display("Checks done, error count %0d", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: pcie_config_top.sv
`default_nettype none

module pcie_config_top (
  input  wire                   pcie_clk,
  input  wire                   pcie_rst,
  input  cfg_pkg::axil_req_t    axil_req_i,
  output cfg_pkg::axil_rsp_t    axil_rsp_o,
  output cfg_pkg::dma_desc_t    dma_rd_desc_o,
  output logic                  dma_rd_desc_valid_o,
  input  wire                   dma_rd_desc_ready_i,
  output cfg_pkg::dma_desc_t    dma_wr_desc_o,
  output logic                  dma_wr_desc_valid_o,
  input  wire                   dma_wr_desc_ready_i,
  input  cfg_pkg::dma_status_t  dma_rd_status_i,
  input  cfg_pkg::dma_status_t  dma_wr_status_i,
  output cfg_pkg::host_cmd_t    host_cmd_o,
  output logic                  host_cmd_valid_o,
  input  wire                   host_cmd_ready_i,
  input  cfg_pkg::gpio_in_t     gpio_in_i,
  output cfg_pkg::gpio_out_t    gpio_out_o,
  output logic                  scl_t_o,
  output logic                  sda_t_o,
  output logic                  pcie_dma_enable_o
);

  import cfg_pkg::*;

  reg_wr_t                reg_wr;
  reg_rd_t                reg_rd;
  reg_wr_t                chan_wr;
  logic [AXIL_DATA_W-1:0] rd_data;
  logic                   rd_chan_sel;
  logic                   wr_chan_sel;
  logic                   rd_status_read;
  logic                   wr_status_read;
  logic [DMA_TAG_W-1:0]   rd_status_tags;
  logic [DMA_TAG_W-1:0]   wr_status_tags;
  gpio_out_t              gpio_out_reg;
  gpio_out_t              gpio_out_echo;
  gpio_in_t               gpio_in_sync;

  axil_ctrl_port axil_port (
    .pcie_clk   (pcie_clk),
    .pcie_rst   (pcie_rst),
    .axil_req_i (axil_req_i),
    .rd_data_i  (rd_data),
    .axil_rsp_o (axil_rsp_o),
    .reg_wr_o   (reg_wr),
    .reg_rd_o   (reg_rd)
  );

  cfg_regs regs (
    .pcie_clk          (pcie_clk),
    .pcie_rst          (pcie_rst),
    .reg_wr_i          (reg_wr),
    .reg_rd_i          (reg_rd),
    .rd_status_tags_i  (rd_status_tags),
    .wr_status_tags_i  (wr_status_tags),
    .gpio_in_i         (gpio_in_sync),
    .gpio_out_echo_i   (gpio_out_echo),
    .host_cmd_ready_i  (host_cmd_ready_i),
    .rd_data_o         (rd_data),
    .chan_wr_o         (chan_wr),
    .rd_chan_sel_o     (rd_chan_sel),
    .wr_chan_sel_o     (wr_chan_sel),
    .rd_status_read_o  (rd_status_read),
    .wr_status_read_o  (wr_status_read),
    .gpio_out_o        (gpio_out_reg),
    .pcie_dma_enable_o (pcie_dma_enable_o),
    .host_cmd_o        (host_cmd_o),
    .host_cmd_valid_o  (host_cmd_valid_o)
  );

  dma_desc_chan dma_rd_chan (
    .pcie_clk      (pcie_clk),
    .pcie_rst      (pcie_rst),
    .reg_wr_i      (chan_wr),
    .sel_i         (rd_chan_sel),
    .status_read_i (rd_status_read),
    .status_i      (dma_rd_status_i),
    .desc_ready_i  (dma_rd_desc_ready_i),
    .desc_o        (dma_rd_desc_o),
    .desc_valid_o  (dma_rd_desc_valid_o),
    .status_tags_o (rd_status_tags)
  );

  dma_desc_chan dma_wr_chan (
    .pcie_clk      (pcie_clk),
    .pcie_rst      (pcie_rst),
    .reg_wr_i      (chan_wr),
    .sel_i         (wr_chan_sel),
    .status_read_i (wr_status_read),
    .status_i      (dma_wr_status_i),
    .desc_ready_i  (dma_wr_desc_ready_i),
    .desc_o        (dma_wr_desc_o),
    .desc_valid_o  (dma_wr_desc_valid_o),
    .status_tags_o (wr_status_tags)
  );

  qsfp_gpio_io gpio_io (
    .pcie_clk        (pcie_clk),
    .pcie_rst        (pcie_rst),
    .gpio_out_i      (gpio_out_reg),
    .gpio_in_i       (gpio_in_i),
    .gpio_out_o      (gpio_out_o),
    .scl_t_o         (scl_t_o),
    .sda_t_o         (sda_t_o),
    .gpio_out_echo_o (gpio_out_echo),
    .gpio_in_sync_o  (gpio_in_sync)
  );

endmodule

`default_nettype wire

// File: qsfp_gpio_io.sv
`default_nettype none

module qsfp_gpio_io (
  input  wire                 pcie_clk,
  input  wire                 pcie_rst,
  input  cfg_pkg::gpio_out_t  gpio_out_i,
  input  cfg_pkg::gpio_in_t   gpio_in_i,
  output cfg_pkg::gpio_out_t  gpio_out_o,
  output logic                scl_t_o,
  output logic                sda_t_o,
  output cfg_pkg::gpio_out_t  gpio_out_echo_o,
  output cfg_pkg::gpio_in_t   gpio_in_sync_o
);

  import cfg_pkg::*;

  gpio_out_t out_q1;
  gpio_out_t out_q2;
  gpio_in_t  in_q1;
  gpio_in_t  in_q2;

  // Two register stages toward the pins, two from them
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      out_q1 <= GPIO_OUT_RST;
      out_q2 <= GPIO_OUT_RST;
      in_q1  <= GPIO_IN_RST;
      in_q2  <= GPIO_IN_RST;
    end else begin
      out_q1 <= gpio_out_i;
      out_q2 <= out_q1;
      in_q1  <= gpio_in_i;
      in_q2  <= in_q1;
    end
  end

  assign gpio_out_o = out_q2;

  // Open drain: release the line when driving high
  assign scl_t_o = out_q2.scl_o;
  assign sda_t_o = out_q2.sda_o;

  assign gpio_out_echo_o = out_q2;
  assign gpio_in_sync_o  = in_q2;

endmodule

`default_nettype wire

// File: dma_desc_chan.sv
`default_nettype none

module dma_desc_chan (
  input  wire                             pcie_clk,
  input  wire                             pcie_rst,
  input  cfg_pkg::reg_wr_t                reg_wr_i,
  input  wire                             sel_i,
  input  wire                             status_read_i,
  input  cfg_pkg::dma_status_t            status_i,
  input  wire                             desc_ready_i,
  output cfg_pkg::dma_desc_t              desc_o,
  output logic                            desc_valid_o,
  output logic [cfg_pkg::DMA_TAG_W-1:0]   status_tags_o
);

  import cfg_pkg::*;

  dma_desc_t            desc_q;
  logic                 valid_q;
  logic [DMA_TAG_W-1:0] tags_q;
  logic                 wr_hit;
  logic [DMA_WIN_W-1:0] ofs;

  assign wr_hit = reg_wr_i.en && sel_i;
  assign ofs    = reg_wr_i.addr[DMA_WIN_W-1:0];

  always_ff @(posedge pcie_clk) begin
    if (wr_hit) begin
      case (ofs)
        OFS_PCIE_LO: desc_q.pcie_addr[31:0]  <= reg_wr_i.data;
        OFS_PCIE_HI: desc_q.pcie_addr[63:32] <= reg_wr_i.data;
        OFS_RAM:     desc_q.ram_addr         <= reg_wr_i.data[RAM_ADDR_W-1:0];
        OFS_LEN:     desc_q.len              <= reg_wr_i.data[DMA_LEN_W-1:0];
        OFS_TAG:     desc_q.tag              <= reg_wr_i.data[DMA_TAG_W-1:0];
        default:     ;
      endcase
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      valid_q <= 1'b0;
      tags_q  <= '0;
    end else begin
      // Tag write issues, and a rewrite keeps valid up
      if (wr_hit && (ofs == OFS_TAG)) begin
        valid_q <= 1'b1;
      end else if (desc_ready_i) begin
        valid_q <= 1'b0;
      end
      if (status_read_i) begin
        tags_q <= status_i.valid ? status_i.tag : '0;
      end else if (status_i.valid) begin
        tags_q <= tags_q | status_i.tag;
      end
    end
  end

  assign desc_o        = desc_q;
  assign desc_valid_o  = valid_q;
  assign status_tags_o = tags_q;

endmodule

`default_nettype wire

// File: cfg_regs.sv
`default_nettype none

module cfg_regs (
  input  wire                             pcie_clk,
  input  wire                             pcie_rst,
  input  cfg_pkg::reg_wr_t                reg_wr_i,
  input  cfg_pkg::reg_rd_t                reg_rd_i,
  input  wire [cfg_pkg::DMA_TAG_W-1:0]    rd_status_tags_i,
  input  wire [cfg_pkg::DMA_TAG_W-1:0]    wr_status_tags_i,
  input  cfg_pkg::gpio_in_t               gpio_in_i,
  input  cfg_pkg::gpio_out_t              gpio_out_echo_i,
  input  wire                             host_cmd_ready_i,
  output logic [cfg_pkg::AXIL_DATA_W-1:0] rd_data_o,
  output cfg_pkg::reg_wr_t                chan_wr_o,
  output logic                            rd_chan_sel_o,
  output logic                            wr_chan_sel_o,
  output logic                            rd_status_read_o,
  output logic                            wr_status_read_o,
  output cfg_pkg::gpio_out_t              gpio_out_o,
  output logic                            pcie_dma_enable_o,
  output cfg_pkg::host_cmd_t              host_cmd_o,
  output logic                            host_cmd_valid_o
);

  import cfg_pkg::*;

  gpio_out_t              gpio_q;
  host_cmd_t              cmd_q;
  logic                   dma_en_q;
  logic                   cmd_valid_q;
  logic [AXIL_DATA_W-1:0] gpio_out_word;
  logic [AXIL_DATA_W-1:0] gpio_in_word;
  logic                   wr_gpio;
  logic                   wr_cmd;

  assign wr_gpio = reg_wr_i.en && (reg_wr_i.addr == ADDR_GPIO_OUT);
  assign wr_cmd  = reg_wr_i.en && (reg_wr_i.addr == ADDR_CMD);

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      gpio_q      <= GPIO_OUT_RST;
      dma_en_q    <= 1'b1;
      cmd_valid_q <= 1'b0;
    end else begin
      if (wr_gpio && reg_wr_i.strb[0]) begin
        gpio_q.qsfp0_resetl <= reg_wr_i.data[0];
        gpio_q.qsfp0_lpmode <= reg_wr_i.data[2];
        gpio_q.qsfp1_resetl <= reg_wr_i.data[4];
        gpio_q.qsfp1_lpmode <= reg_wr_i.data[6];
      end
      if (wr_gpio && reg_wr_i.strb[1]) begin
        gpio_q.qsfp0_modsell <= reg_wr_i.data[9];
        gpio_q.qsfp1_modsell <= reg_wr_i.data[11];
      end
      if (wr_gpio && reg_wr_i.strb[2]) begin
        gpio_q.scl_o <= reg_wr_i.data[16];
        gpio_q.sda_o <= reg_wr_i.data[17];
      end
      if (reg_wr_i.en && (reg_wr_i.addr == ADDR_DMA_EN)) begin
        dma_en_q <= reg_wr_i.data[0];
      end
      // A new command wins over a same-cycle ready
      if (wr_cmd) begin
        cmd_valid_q <= 1'b1;
      end else if (host_cmd_ready_i) begin
        cmd_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (reg_wr_i.en && (reg_wr_i.addr == ADDR_CMD_DATA)) begin
      cmd_q.data <= reg_wr_i.data;
    end
    if (wr_cmd) begin
      cmd_q.code <= reg_wr_i.data[CMD_W-1:0];
      cmd_q.dest <= reg_wr_i.data[8 +: CORE_W];
    end
  end

  // Window base only, channels decode the offset
  assign chan_wr_o     = reg_wr_i;
  assign rd_chan_sel_o = reg_wr_i.addr[AXIL_ADDR_W-1:DMA_WIN_W] ==
                         ADDR_DMA_RD_BASE[AXIL_ADDR_W-1:DMA_WIN_W];
  assign wr_chan_sel_o = reg_wr_i.addr[AXIL_ADDR_W-1:DMA_WIN_W] ==
                         ADDR_DMA_WR_BASE[AXIL_ADDR_W-1:DMA_WIN_W];

  assign rd_status_read_o = reg_rd_i.en &&
                            (reg_rd_i.addr == (ADDR_DMA_RD_BASE | AXIL_ADDR_W'(OFS_STATUS)));
  assign wr_status_read_o = reg_rd_i.en &&
                            (reg_rd_i.addr == (ADDR_DMA_WR_BASE | AXIL_ADDR_W'(OFS_STATUS)));

  always_comb begin
    gpio_out_word     = '0;
    gpio_out_word[0]  = gpio_q.qsfp0_resetl;
    gpio_out_word[2]  = gpio_q.qsfp0_lpmode;
    gpio_out_word[4]  = gpio_q.qsfp1_resetl;
    gpio_out_word[6]  = gpio_q.qsfp1_lpmode;
    gpio_out_word[9]  = gpio_q.qsfp0_modsell;
    gpio_out_word[11] = gpio_q.qsfp1_modsell;
    gpio_out_word[16] = gpio_q.scl_o;
    gpio_out_word[17] = gpio_q.sda_o;
  end

  // Pin view, outputs echoed from the last pipeline stage
  always_comb begin
    gpio_in_word     = '0;
    gpio_in_word[0]  = gpio_out_echo_i.qsfp0_resetl;
    gpio_in_word[1]  = gpio_in_i.qsfp0_intl;
    gpio_in_word[2]  = gpio_out_echo_i.qsfp0_lpmode;
    gpio_in_word[4]  = gpio_out_echo_i.qsfp1_resetl;
    gpio_in_word[5]  = gpio_in_i.qsfp1_intl;
    gpio_in_word[6]  = gpio_out_echo_i.qsfp1_lpmode;
    gpio_in_word[8]  = gpio_in_i.qsfp0_modprsl;
    gpio_in_word[9]  = gpio_out_echo_i.qsfp0_modsell;
    gpio_in_word[10] = gpio_in_i.qsfp1_modprsl;
    gpio_in_word[11] = gpio_out_echo_i.qsfp1_modsell;
    gpio_in_word[16] = gpio_in_i.scl_i;
    gpio_in_word[17] = gpio_in_i.sda_i;
  end

  always_comb begin
    rd_data_o = '0;
    case (reg_rd_i.addr)
      ADDR_FW_ID:          rd_data_o = FW_ID;
      ADDR_FW_VER:         rd_data_o = FW_VER;
      ADDR_BOARD_ID:       rd_data_o = BOARD_ID;
      ADDR_BOARD_VER:      rd_data_o = BOARD_VER;
      ADDR_PHC_OFFSET:     rd_data_o = PHC_OFFSET;
      ADDR_PHC_STRIDE:     rd_data_o = PHC_STRIDE;
      ADDR_IF_COUNT:       rd_data_o = IF_COUNT;
      ADDR_IF_STRIDE:      rd_data_o = IF_STRIDE;
      ADDR_IF_CTRL_OFFSET: rd_data_o = IF_CTRL_OFFSET;
      ADDR_FPGA_ID:        rd_data_o = FPGA_ID;
      ADDR_GPIO_OUT:       rd_data_o = gpio_out_word;
      ADDR_GPIO_IN:        rd_data_o = gpio_in_word;
      ADDR_DMA_EN:         rd_data_o = {{(AXIL_DATA_W-1){1'b0}}, dma_en_q};
      ADDR_DMA_RD_BASE | AXIL_ADDR_W'(OFS_STATUS): rd_data_o = rd_status_tags_i;
      ADDR_DMA_WR_BASE | AXIL_ADDR_W'(OFS_STATUS): rd_data_o = wr_status_tags_i;
      default:             rd_data_o = '0;
    endcase
  end

  assign gpio_out_o        = gpio_q;
  assign pcie_dma_enable_o = dma_en_q;
  assign host_cmd_o        = cmd_q;
  assign host_cmd_valid_o  = cmd_valid_q;

endmodule

`default_nettype wire

// File: axil_ctrl_port.sv
`default_nettype none

module axil_ctrl_port (
  input  wire                               pcie_clk,
  input  wire                               pcie_rst,
  input  cfg_pkg::axil_req_t                axil_req_i,
  input  wire [cfg_pkg::AXIL_DATA_W-1:0]    rd_data_i,
  output cfg_pkg::axil_rsp_t                axil_rsp_o,
  output cfg_pkg::reg_wr_t                  reg_wr_o,
  output cfg_pkg::reg_rd_t                  reg_rd_o
);

  import cfg_pkg::*;

  logic                   awready_q;
  logic                   wready_q;
  logic                   bvalid_q;
  logic                   arready_q;
  logic                   rvalid_q;
  logic [AXIL_DATA_W-1:0] rdata_q;
  logic                   wr_acc;
  logic                   rd_acc;

  // Accept only while no response of the same kind is pending
  assign wr_acc = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
  assign rd_acc = axil_req_i.arvalid && !rvalid_q;

  // Strobes act on the accepting edge
  assign reg_wr_o.en   = wr_acc;
  assign reg_wr_o.addr = {axil_req_i.awaddr[AXIL_ADDR_W-1:2], 2'b00};
  assign reg_wr_o.data = axil_req_i.wdata;
  assign reg_wr_o.strb = axil_req_i.wstrb;

  assign reg_rd_o.en   = rd_acc;
  assign reg_rd_o.addr = {axil_req_i.araddr[AXIL_ADDR_W-1:2], 2'b00};

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      awready_q <= wr_acc;
      wready_q  <= wr_acc;
      arready_q <= rd_acc;
      if (wr_acc) begin
        bvalid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_acc) begin
        rvalid_q <= 1'b1;
      end else if (axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Read data held until the next accepted read
  always_ff @(posedge pcie_clk) begin
    if (rd_acc) begin
      rdata_q <= rd_data_i;
    end
  end

  assign axil_rsp_o.awready = awready_q;
  assign axil_rsp_o.wready  = wready_q;
  assign axil_rsp_o.bvalid  = bvalid_q;
  assign axil_rsp_o.arready = arready_q;
  assign axil_rsp_o.rvalid  = rvalid_q;
  assign axil_rsp_o.rdata   = rdata_q;

endmodule

`default_nettype wire

// File: cfg_pkg.sv
`default_nettype none

package cfg_pkg;

  localparam int AXIL_ADDR_W = 16;
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_STRB_W = 4;
  localparam int PCIE_ADDR_W = 64;
  localparam int RAM_ADDR_W  = 32;
  localparam int DMA_LEN_W   = 16;
  localparam int DMA_TAG_W   = 32;
  localparam int CORE_W      = 4;
  localparam int CMD_W       = 4;
  localparam int DMA_WIN_W   = 5;

  // Identity words
  localparam logic [31:0] FW_ID     = 32'h0000_0000;
  localparam logic [31:0] FW_VER    = 32'h0000_0001;
  localparam logic [31:0] BOARD_ID  = 32'h1ce4_0003;
  localparam logic [31:0] BOARD_VER = 32'h0000_0001;
  localparam logic [31:0] FPGA_ID   = 32'h0382_3093;

  // Layout words, interface space split over a 16-bit window
  localparam logic [31:0] PHC_OFFSET     = 32'h0000_0200;
  localparam logic [31:0] PHC_STRIDE     = 32'h0000_0080;
  localparam logic [31:0] IF_COUNT       = 32'h0000_0002;
  localparam logic [31:0] IF_STRIDE      = 32'h0000_8000;
  localparam logic [31:0] IF_CTRL_OFFSET = 32'h0000_0400;

  localparam logic [AXIL_ADDR_W-1:0] ADDR_FW_ID          = 16'h0000;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_FW_VER         = 16'h0004;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_BOARD_ID       = 16'h0008;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_BOARD_VER      = 16'h000C;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_PHC_OFFSET     = 16'h0014;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_PHC_STRIDE     = 16'h0018;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_IF_COUNT       = 16'h0020;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_IF_STRIDE      = 16'h0024;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_IF_CTRL_OFFSET = 16'h002C;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_FPGA_ID        = 16'h0040;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_GPIO_OUT       = 16'h0100;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_GPIO_IN        = 16'h0104;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_DMA_EN         = 16'h0400;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_CMD_DATA       = 16'h0404;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_CMD            = 16'h0408;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_DMA_RD_BASE    = 16'h0440;
  localparam logic [AXIL_ADDR_W-1:0] ADDR_DMA_WR_BASE    = 16'h0460;

  // Offsets inside a DMA descriptor window
  localparam logic [DMA_WIN_W-1:0] OFS_PCIE_LO = 5'h00;
  localparam logic [DMA_WIN_W-1:0] OFS_PCIE_HI = 5'h04;
  localparam logic [DMA_WIN_W-1:0] OFS_RAM     = 5'h08;
  localparam logic [DMA_WIN_W-1:0] OFS_LEN     = 5'h10;
  localparam logic [DMA_WIN_W-1:0] OFS_TAG     = 5'h14;
  localparam logic [DMA_WIN_W-1:0] OFS_STATUS  = 5'h18;

  typedef struct packed {
    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic [AXIL_DATA_W-1:0] wdata;
    logic [AXIL_STRB_W-1:0] wstrb;
    logic                   wvalid;
    logic                   bready;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   rready;
  } axil_req_t;

  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic                   arready;
    logic                   rvalid;
    logic [AXIL_DATA_W-1:0] rdata;
  } axil_rsp_t;

  typedef struct packed {
    logic                   en;
    logic [AXIL_ADDR_W-1:0] addr;
    logic [AXIL_DATA_W-1:0] data;
    logic [AXIL_STRB_W-1:0] strb;
  } reg_wr_t;

  typedef struct packed {
    logic                   en;
    logic [AXIL_ADDR_W-1:0] addr;
  } reg_rd_t;

  typedef struct packed {
    logic [PCIE_ADDR_W-1:0] pcie_addr;
    logic [RAM_ADDR_W-1:0]  ram_addr;
    logic [DMA_LEN_W-1:0]   len;
    logic [DMA_TAG_W-1:0]   tag;
  } dma_desc_t;

  typedef struct packed {
    logic                 valid;
    logic [DMA_TAG_W-1:0] tag;
  } dma_status_t;

  typedef struct packed {
    logic [CMD_W-1:0]       code;
    logic [CORE_W-1:0]      dest;
    logic [AXIL_DATA_W-1:0] data;
  } host_cmd_t;

  typedef struct packed {
    logic qsfp0_modsell;
    logic qsfp0_resetl;
    logic qsfp0_lpmode;
    logic qsfp1_modsell;
    logic qsfp1_resetl;
    logic qsfp1_lpmode;
    logic scl_o;
    logic sda_o;
  } gpio_out_t;

  typedef struct packed {
    logic qsfp0_modprsl;
    logic qsfp0_intl;
    logic qsfp1_modprsl;
    logic qsfp1_intl;
    logic scl_i;
    logic sda_i;
  } gpio_in_t;

  // Modules deselected, out of reset, full power, I2C released
  localparam gpio_out_t GPIO_OUT_RST = '{
    qsfp0_modsell: 1'b1, qsfp0_resetl: 1'b1, qsfp0_lpmode: 1'b0,
    qsfp1_modsell: 1'b1, qsfp1_resetl: 1'b1, qsfp1_lpmode: 1'b0,
    scl_o: 1'b1, sda_o: 1'b1
  };

  localparam gpio_in_t GPIO_IN_RST = '{
    qsfp0_modprsl: 1'b0, qsfp0_intl: 1'b0,
    qsfp1_modprsl: 1'b0, qsfp1_intl: 1'b0,
    scl_i: 1'b1, sda_i: 1'b1
  };

endpackage

`default_nettype wire
